/* source/eth_pkg.sv */
package eth_pkg;

    // frame sizes in bytes, fcs included
    localparam int min_frame_len = 64;
    localparam int fcs_len = 4;

    typedef logic [31:0] crc_t;

    // reflected crc-32, register starts at all ones
    localparam crc_t crc_init = 32'hffff_ffff;

    // register value left over once a frame and its correct fcs
    // have both gone through the crc
    localparam crc_t crc_residue = 32'hdebb_20e3;

endpackage

/* source/stream_pkg.sv */
package stream_pkg;

    typedef logic [7:0] byte_t;

    // transmit register stage payload
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } tx_beat_t;

    // receive register stage payload, same fields for now
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } rx_beat_t;

endpackage

/* source/eth_crc_8.sv */
`timescale 1ns/1ns

module eth_crc_8 (
    input  stream_pkg::byte_t data,
    input  eth_pkg::crc_t     crc_state,
    output eth_pkg::crc_t     crc_next
);

    import eth_pkg::*;

    // 0x04c11db7 bit reversed
    localparam crc_t poly_reflected = 32'hedb8_8320;

    // lsb first, one shift per data bit
    always_comb begin
        crc_t crc;
        crc = crc_state;
        for (int i = 0; i < 8; i++) begin
            if (crc[0] ^ data[i]) begin
                crc = (crc >> 1) ^ poly_reflected;
            end else begin
                crc = crc >> 1;
            end
        end
        crc_next = crc;
    end

endmodule

/* source/stream_skid_reg.sv */
`timescale 1ns/1ns

module stream_skid_reg #(
    parameter type beat_t = logic [7:0]
) (
    input  logic  clk,
    input  logic  rst,

    input  beat_t s_beat,
    input  logic  s_valid,
    output logic  s_ready,

    output beat_t m_beat,
    output logic  m_valid,
    input  logic  m_ready
);

    beat_t out_beat;
    beat_t spare_beat;
    logic  out_valid;
    logic  spare_valid;
    logic  ready_reg;
    logic  ready_early;

    // room next cycle: downstream drains, both entries free,
    // or spare free and nothing arriving now
    assign ready_early = m_ready
        || (!spare_valid && !out_valid)
        || (!spare_valid && !s_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg   <= 1'b0;
            out_valid   <= 1'b0;
            spare_valid <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (ready_reg) begin
                if (m_ready || !out_valid) begin
                    out_valid <= s_valid;
                end else begin
                    // output stalled, park the beat
                    spare_valid <= s_valid;
                end
            end else if (m_ready) begin
                out_valid   <= spare_valid;
                spare_valid <= 1'b0;
            end
        end
    end

    // payload follows the same selection
    always_ff @(posedge clk) begin
        if (ready_reg) begin
            if (m_ready || !out_valid) begin
                out_beat <= s_beat;
            end else begin
                spare_beat <= s_beat;
            end
        end else if (m_ready) begin
            out_beat <= spare_beat;
        end
    end

    assign s_ready = ready_reg;
    assign m_beat  = out_beat;
    assign m_valid = out_valid;

endmodule

/* source/eth_fcs_insert.sv */
`timescale 1ns/1ns

module eth_fcs_insert #(
    parameter bit enable_padding   = 1'b1,
    parameter int min_frame_length = eth_pkg::min_frame_len
) (
    input  logic              clk,
    input  logic              rst,

    input  stream_pkg::byte_t s_tdata,
    input  logic              s_tvalid,
    output logic              s_tready,
    input  logic              s_tlast,
    input  logic              s_tuser,

    output stream_pkg::byte_t m_tdata,
    output logic              m_tvalid,
    input  logic              m_tready,
    output logic              m_tlast,
    output logic              m_tuser,

    output logic              busy
);

    import eth_pkg::*;
    import stream_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_payload,
        st_pad,
        st_fcs
    } state_t;

    // pointer value of the last byte before the fcs
    localparam logic [15:0] pad_last = 16'(min_frame_length - fcs_len - 1);
    localparam logic [1:0]  fcs_last = 2'(fcs_len - 1);

    state_t      state;
    state_t      state_next;
    logic [15:0] frame_ptr;
    logic [15:0] frame_ptr_next;
    logic        busy_reg;

    crc_t        crc_state;
    crc_t        crc_next;
    crc_t        fcs;
    logic        crc_clear;
    logic        crc_update;

    tx_beat_t    beat;
    logic        beat_valid;
    logic        skid_ready;
    tx_beat_t    out_beat;

    assign fcs = ~crc_state;

    eth_crc_8 eth_crc_8_inst (
        .data      (beat.data),
        .crc_state (crc_state),
        .crc_next  (crc_next)
    );

    // input only open while payload can flow
    assign s_tready = skid_ready && (state == st_idle || state == st_payload);

    always_comb begin
        state_next     = state;
        frame_ptr_next = frame_ptr;
        crc_clear      = 1'b0;
        crc_update     = 1'b0;
        beat           = '0;
        beat_valid     = 1'b0;

        case (state)
            st_idle, st_payload: begin
                beat.data  = s_tdata;
                beat.last  = s_tlast && s_tuser;
                beat.user  = s_tlast && s_tuser;
                beat_valid = s_tvalid;
                if (s_tready && s_tvalid) begin
                    frame_ptr_next = frame_ptr + 16'd1;
                    crc_update     = 1'b1;
                    if (s_tlast && s_tuser) begin
                        // aborted frame goes out as is
                        crc_clear      = 1'b1;
                        frame_ptr_next = '0;
                        state_next     = st_idle;
                    end else if (s_tlast) begin
                        if (enable_padding && frame_ptr < pad_last) begin
                            state_next = st_pad;
                        end else begin
                            frame_ptr_next = '0;
                            state_next     = st_fcs;
                        end
                    end else begin
                        state_next = st_payload;
                    end
                end
            end
            st_pad: begin
                beat_valid = 1'b1;
                if (skid_ready) begin
                    frame_ptr_next = frame_ptr + 16'd1;
                    crc_update     = 1'b1;
                    if (frame_ptr >= pad_last) begin
                        frame_ptr_next = '0;
                        state_next     = st_fcs;
                    end
                end
            end
            st_fcs: begin
                // least significant byte first
                beat.data  = fcs[{frame_ptr[1:0], 3'b000} +: 8];
                beat.last  = (frame_ptr[1:0] == fcs_last);
                beat_valid = 1'b1;
                if (skid_ready) begin
                    frame_ptr_next = frame_ptr + 16'd1;
                    if (frame_ptr[1:0] == fcs_last) begin
                        crc_clear      = 1'b1;
                        frame_ptr_next = '0;
                        state_next     = st_idle;
                    end
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            frame_ptr <= '0;
            busy_reg  <= 1'b0;
            crc_state <= crc_init;
        end else begin
            state     <= state_next;
            frame_ptr <= frame_ptr_next;
            busy_reg  <= (state_next != st_idle);
            if (crc_clear) begin
                crc_state <= crc_init;
            end else if (crc_update) begin
                crc_state <= crc_next;
            end
        end
    end

    assign busy = busy_reg;

    stream_skid_reg #(
        .beat_t (tx_beat_t)
    ) stream_skid_reg_inst (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (beat),
        .s_valid (beat_valid),
        .s_ready (skid_ready),
        .m_beat  (out_beat),
        .m_valid (m_tvalid),
        .m_ready (m_tready)
    );

    assign m_tdata = out_beat.data;
    assign m_tlast = out_beat.last;
    assign m_tuser = out_beat.user;

endmodule

/* source/eth_fcs_check.sv */
`timescale 1ns/1ns

module eth_fcs_check (
    input  logic              clk,
    input  logic              rst,

    input  stream_pkg::byte_t s_tdata,
    input  logic              s_tvalid,
    output logic              s_tready,
    input  logic              s_tlast,
    input  logic              s_tuser,

    output stream_pkg::byte_t m_tdata,
    output logic              m_tvalid,
    input  logic              m_tready,
    output logic              m_tlast,
    output logic              m_tuser,

    output logic              busy
);

    import eth_pkg::*;
    import stream_pkg::*;

    // fcs_len held bytes plus the current one
    localparam logic [2:0] held_max  = 3'(fcs_len);
    localparam logic [2:0] short_cnt = 3'(fcs_len + 1);

    // hold[0] is the newest byte
    byte_t [3:0] hold;
    // bytes seen so far in this frame, saturates at short_cnt
    logic [2:0]  fill_cnt;
    logic        hold_full;
    logic        accept;
    logic        busy_reg;

    crc_t        crc_state;
    crc_t        crc_next;

    byte_t       oldest;
    rx_beat_t    beat;
    logic        beat_valid;
    logic        skid_ready;
    rx_beat_t    out_beat;

    eth_crc_8 eth_crc_8_inst (
        .data      (s_tdata),
        .crc_state (crc_state),
        .crc_next  (crc_next)
    );

    assign s_tready  = skid_ready;
    assign accept    = s_tvalid && s_tready;
    assign hold_full = (fill_cnt >= held_max);

    // oldest byte of the frame not yet emitted
    always_comb begin
        if (fill_cnt == 3'd0) begin
            oldest = s_tdata;
        end else if (hold_full) begin
            oldest = hold[3];
        end else begin
            oldest = hold[fill_cnt[1:0] - 2'd1];
        end
    end

    always_comb begin
        beat.data  = oldest;
        beat.last  = s_tlast;
        beat.user  = 1'b0;
        beat_valid = s_tvalid && (hold_full || s_tlast);
        if (s_tlast) begin
            // bad when flagged upstream, wrong crc or too short
            beat.user = s_tuser
                || (crc_next != crc_residue)
                || (fill_cnt < short_cnt);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_cnt  <= '0;
            crc_state <= crc_init;
            busy_reg  <= 1'b0;
        end else if (accept) begin
            busy_reg <= !s_tlast;
            if (s_tlast) begin
                fill_cnt  <= '0;
                crc_state <= crc_init;
            end else begin
                if (fill_cnt < short_cnt) begin
                    fill_cnt <= fill_cnt + 3'd1;
                end
                crc_state <= crc_next;
            end
        end
    end

    // delay line
    always_ff @(posedge clk) begin
        if (accept) begin
            hold <= {hold[2:0], s_tdata};
        end
    end

    assign busy = busy_reg;

    stream_skid_reg #(
        .beat_t (rx_beat_t)
    ) stream_skid_reg_inst (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (beat),
        .s_valid (beat_valid),
        .s_ready (skid_ready),
        .m_beat  (out_beat),
        .m_valid (m_tvalid),
        .m_ready (m_tready)
    );

    assign m_tdata = out_beat.data;
    assign m_tlast = out_beat.last;
    assign m_tuser = out_beat.user;

endmodule

/* source/eth_fcs_top.sv */
`timescale 1ns/1ns

module eth_fcs_top #(
    parameter bit enable_padding   = 1'b1,
    parameter int min_frame_length = eth_pkg::min_frame_len
) (
    input  logic              clk,
    input  logic              rst,

    // transmit, payload in
    input  stream_pkg::byte_t s_tx_tdata,
    input  logic              s_tx_tvalid,
    output logic              s_tx_tready,
    input  logic              s_tx_tlast,
    input  logic              s_tx_tuser,

    // transmit, padded frame with fcs out
    output stream_pkg::byte_t m_tx_tdata,
    output logic              m_tx_tvalid,
    input  logic              m_tx_tready,
    output logic              m_tx_tlast,
    output logic              m_tx_tuser,
    output logic              tx_busy,

    // receive, frame with fcs in
    input  stream_pkg::byte_t s_rx_tdata,
    input  logic              s_rx_tvalid,
    output logic              s_rx_tready,
    input  logic              s_rx_tlast,
    input  logic              s_rx_tuser,

    // receive, fcs stripped, user marks a bad frame
    output stream_pkg::byte_t m_rx_tdata,
    output logic              m_rx_tvalid,
    input  logic              m_rx_tready,
    output logic              m_rx_tlast,
    output logic              m_rx_tuser,
    output logic              rx_busy
);

    eth_fcs_insert #(
        .enable_padding   (enable_padding),
        .min_frame_length (min_frame_length)
    ) eth_fcs_insert_inst (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (s_tx_tdata),
        .s_tvalid (s_tx_tvalid),
        .s_tready (s_tx_tready),
        .s_tlast  (s_tx_tlast),
        .s_tuser  (s_tx_tuser),
        .m_tdata  (m_tx_tdata),
        .m_tvalid (m_tx_tvalid),
        .m_tready (m_tx_tready),
        .m_tlast  (m_tx_tlast),
        .m_tuser  (m_tx_tuser),
        .busy     (tx_busy)
    );

    eth_fcs_check eth_fcs_check_inst (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (s_rx_tdata),
        .s_tvalid (s_rx_tvalid),
        .s_tready (s_rx_tready),
        .s_tlast  (s_rx_tlast),
        .s_tuser  (s_rx_tuser),
        .m_tdata  (m_rx_tdata),
        .m_tvalid (m_rx_tvalid),
        .m_tready (m_rx_tready),
        .m_tlast  (m_rx_tlast),
        .m_tuser  (m_rx_tuser),
        .busy     (rx_busy)
    );

endmodule

/* tb/eth_fcs_top_tb.sv */
`timescale 1ns/1ns

module eth_fcs_top_tb;

    import eth_pkg::*;
    import stream_pkg::*;

    localparam int timeout_cycles = 2000;
    localparam int max_records    = 32;

    logic  clk;
    logic  rst;
    byte_t s_tx_tdata;
    logic  s_tx_tvalid;
    logic  s_tx_tready;
    logic  s_tx_tlast;
    logic  s_tx_tuser;
    byte_t m_tx_tdata;
    logic  m_tx_tvalid;
    logic  m_tx_tready;
    logic  m_tx_tlast;
    logic  m_tx_tuser;
    logic  tx_busy;
    byte_t s_rx_tdata;
    logic  s_rx_tvalid;
    logic  s_rx_tready;
    logic  s_rx_tlast;
    logic  s_rx_tuser;
    byte_t m_rx_tdata;
    logic  m_rx_tvalid;
    logic  m_rx_tready;
    logic  m_rx_tlast;
    logic  m_rx_tuser;
    logic  rx_busy;

    logic  random_mode;
    int    errors;

    // output beats, one set of queues per path
    byte_t tx_data_q[$];
    logic  tx_last_q[$];
    logic  tx_user_q[$];
    byte_t rx_data_q[$];
    logic  rx_last_q[$];
    logic  rx_user_q[$];

    string rec_name[max_records];
    int    rec_path[max_records];
    int    rec_len[max_records];
    int    rec_base[max_records];
    int    rec_step[max_records];
    int    rec_mode[max_records];
    int    rec_exp_len[max_records];
    int    rec_exp_user[max_records];
    int    rec_count;

    eth_fcs_top #(
        .enable_padding (1'b1)
    ) eth_fcs_top_inst (
        .clk         (clk),
        .rst         (rst),
        .s_tx_tdata  (s_tx_tdata),
        .s_tx_tvalid (s_tx_tvalid),
        .s_tx_tready (s_tx_tready),
        .s_tx_tlast  (s_tx_tlast),
        .s_tx_tuser  (s_tx_tuser),
        .m_tx_tdata  (m_tx_tdata),
        .m_tx_tvalid (m_tx_tvalid),
        .m_tx_tready (m_tx_tready),
        .m_tx_tlast  (m_tx_tlast),
        .m_tx_tuser  (m_tx_tuser),
        .tx_busy     (tx_busy),
        .s_rx_tdata  (s_rx_tdata),
        .s_rx_tvalid (s_rx_tvalid),
        .s_rx_tready (s_rx_tready),
        .s_rx_tlast  (s_rx_tlast),
        .s_rx_tuser  (s_rx_tuser),
        .m_rx_tdata  (m_rx_tdata),
        .m_rx_tvalid (m_rx_tvalid),
        .m_rx_tready (m_rx_tready),
        .m_rx_tlast  (m_rx_tlast),
        .m_rx_tuser  (m_rx_tuser),
        .rx_busy     (rx_busy)
    );

    always #4 clk = ~clk;

    // output back-pressure, changed on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            m_tx_tready = random_mode ? ($urandom_range(3) != 0) : 1'b1;
            m_rx_tready = random_mode ? ($urandom_range(3) != 0) : 1'b1;
        end
    end

    always @(posedge clk) begin
        if (m_tx_tvalid && m_tx_tready) begin
            tx_data_q.push_back(m_tx_tdata);
            tx_last_q.push_back(m_tx_tlast);
            tx_user_q.push_back(m_tx_tuser);
        end
        if (m_rx_tvalid && m_rx_tready) begin
            rx_data_q.push_back(m_rx_tdata);
            rx_last_q.push_back(m_rx_tlast);
            rx_user_q.push_back(m_rx_tuser);
        end
    end

    // standard crc-32, bit by bit, result already inverted
    function automatic logic [31:0] crc32_ref(input byte_t bytes[$]);
        logic [31:0] r;
        logic        fb;
        r = 32'hffff_ffff;
        foreach (bytes[k]) begin
            for (int b = 0; b < 8; b++) begin
                fb = r[0] ^ bytes[k][b];
                r  = {1'b0, r[31:1]} ^ ({32{fb}} & 32'hedb8_8320);
            end
        end
        return ~r;
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic compare_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) begin
            $display("Error in %s: expected byte %h, actual %h", name, exp, act);
            errors++;
            stop_run("data byte mismatch");
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error in %s: expected flag %b, actual %b", name, exp, act);
            errors++;
            stop_run("flag mismatch");
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Error in %s: expected %0d beats, actual %0d", name, exp, act);
            errors++;
            stop_run("beat count mismatch");
        end
    endtask

    task automatic check_busy(input string name, input logic tx_exp, input logic rx_exp);
        compare_flag({name, " tx_busy"}, tx_exp, tx_busy);
        compare_flag({name, " rx_busy"}, rx_exp, rx_busy);
    endtask

    task automatic send_frame(input string name, input int path, input byte_t bytes[$],
        input logic user);
        int gap;
        int wait_cnt;
        logic ready;
        for (int i = 0; i < bytes.size(); i++) begin
            gap = random_mode ? $urandom_range(2) : 0;
            @(negedge clk);
            // busy from the first accepted byte on
            if (path == 0) begin
                check_busy(name, i > 0, 1'b0);
            end else begin
                check_busy(name, 1'b0, i > 0);
            end
            s_tx_tvalid = 1'b0;
            s_rx_tvalid = 1'b0;
            repeat (gap) @(negedge clk);
            if (path == 0) begin
                s_tx_tdata  = bytes[i];
                s_tx_tlast  = (i == bytes.size() - 1);
                s_tx_tuser  = user && (i == bytes.size() - 1);
                s_tx_tvalid = 1'b1;
            end else begin
                s_rx_tdata  = bytes[i];
                s_rx_tlast  = (i == bytes.size() - 1);
                s_rx_tuser  = user && (i == bytes.size() - 1);
                s_rx_tvalid = 1'b1;
            end
            wait_cnt = 0;
            ready = (path == 0) ? s_tx_tready : s_rx_tready;
            while (!ready) begin
                @(negedge clk);
                wait_cnt++;
                if (wait_cnt > timeout_cycles) begin
                    stop_run("input ready stayed low, the DUT stopped taking bytes");
                end
                ready = (path == 0) ? s_tx_tready : s_rx_tready;
            end
            @(posedge clk);
        end
        @(negedge clk);
        // transmit still owes padding and fcs, receive is done
        check_busy(name, path == 0 && !user, 1'b0);
        s_tx_tvalid = 1'b0;
        s_tx_tlast  = 1'b0;
        s_tx_tuser  = 1'b0;
        s_rx_tvalid = 1'b0;
        s_rx_tlast  = 1'b0;
        s_rx_tuser  = 1'b0;
    endtask

    task automatic run_record(input int r);
        byte_t       payload[$];
        byte_t       frame[$];
        byte_t       expect_q[$];
        logic [31:0] fcs;
        int          keep;
        int          wait_cnt;
        logic        done;
        for (int i = 0; i < rec_len[r]; i++) begin
            payload.push_back(byte_t'(rec_base[r] + i * rec_step[r]));
        end
        frame = payload;
        if (rec_path[r] == 0) begin
            if (rec_mode[r] == 1) begin
                // aborted frame passes untouched
                expect_q = payload;
            end else begin
                while (frame.size() < min_frame_len - fcs_len) begin
                    frame.push_back(8'h00);
                end
                fcs = crc32_ref(frame);
                expect_q = frame;
                for (int k = 0; k < fcs_len; k++) begin
                    expect_q.push_back(fcs[8*k +: 8]);
                end
            end
        end else begin
            if (rec_mode[r] >= 1) begin
                fcs = crc32_ref(payload);
                for (int k = 0; k < fcs_len; k++) begin
                    frame.push_back(fcs[8*k +: 8]);
                end
            end
            if (rec_mode[r] == 2) begin
                frame[3] = frame[3] ^ 8'h01;
            end
            // fcs stripped, short frames still give one byte
            keep = (frame.size() > fcs_len) ? frame.size() - fcs_len : 1;
            for (int k = 0; k < keep; k++) begin
                expect_q.push_back(frame[k]);
            end
        end
        compare_count(rec_name[r], rec_exp_len[r], expect_q.size());

        tx_data_q.delete();
        tx_last_q.delete();
        tx_user_q.delete();
        rx_data_q.delete();
        rx_last_q.delete();
        rx_user_q.delete();
        if (rec_path[r] == 0) begin
            send_frame(rec_name[r], 0, payload, rec_mode[r] == 1);
        end else begin
            send_frame(rec_name[r], 1, frame, 1'b0);
        end

        wait_cnt = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (rec_path[r] == 0) begin
                done = (tx_last_q.size() > 0) && tx_last_q[$];
            end else begin
                done = (rx_last_q.size() > 0) && rx_last_q[$];
            end
            wait_cnt++;
            if (!done && wait_cnt > timeout_cycles) begin
                if (rec_path[r] == 0) begin
                    stop_run("transmit output never delivered the last beat");
                end else begin
                    stop_run("receive output never delivered the last beat");
                end
            end
        end

        // both paths idle once the frame is out
        check_busy(rec_name[r], 1'b0, 1'b0);

        if (rec_path[r] == 0) begin
            compare_count(rec_name[r], expect_q.size(), tx_data_q.size());
            foreach (expect_q[i]) begin
                compare_byte(rec_name[r], expect_q[i], tx_data_q[i]);
                compare_flag(rec_name[r], i == expect_q.size() - 1, tx_last_q[i]);
                compare_flag(rec_name[r], (i == expect_q.size() - 1) && rec_exp_user[r] != 0,
                    tx_user_q[i]);
            end
        end else begin
            compare_count(rec_name[r], expect_q.size(), rx_data_q.size());
            foreach (expect_q[i]) begin
                compare_byte(rec_name[r], expect_q[i], rx_data_q[i]);
                compare_flag(rec_name[r], i == expect_q.size() - 1, rx_last_q[i]);
                compare_flag(rec_name[r], (i == expect_q.size() - 1) && rec_exp_user[r] != 0,
                    rx_user_q[i]);
            end
        end
    endtask

    task automatic read_stim();
        int    fd;
        int    n;
        string line;
        string name;
        int    f[7];
        fd = $fopen("tb/eth_fcs_stim.txt", "r");
        if (fd == 0) begin
            stop_run("could not open the stimulus file");
        end
        rec_count = 0;
        while (!$feof(fd) && rec_count < max_records) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%s %d %d %h %h %d %d %d", name,
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                if (n == 8) begin
                    rec_name[rec_count]     = name;
                    rec_path[rec_count]     = f[0];
                    rec_len[rec_count]      = f[1];
                    rec_base[rec_count]     = f[2];
                    rec_step[rec_count]     = f[3];
                    rec_mode[rec_count]     = f[4];
                    rec_exp_len[rec_count]  = f[5];
                    rec_exp_user[rec_count] = f[6];
                    rec_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        byte_t check_q[$];
        clk         = 1'b0;
        rst         = 1'b1;
        s_tx_tdata  = '0;
        s_tx_tvalid = 1'b0;
        s_tx_tlast  = 1'b0;
        s_tx_tuser  = 1'b0;
        m_tx_tready = 1'b0;
        s_rx_tdata  = '0;
        s_rx_tvalid = 1'b0;
        s_rx_tlast  = 1'b0;
        s_rx_tuser  = 1'b0;
        m_rx_tready = 1'b0;
        random_mode = 1'b0;
        errors      = 0;
        void'($urandom(32'hbcfaa78a));

        // reference model against the published check value of "123456789"
        for (int k = 0; k < 9; k++) begin
            check_q.push_back(byte_t'(8'h31 + k));
        end
        if (crc32_ref(check_q) != 32'hcbf4_3926) begin
            stop_run("reference crc does not match the standard check value");
        end

        read_stim();
        if (rec_count == 0) begin
            stop_run("the stimulus file holds no records");
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // first pass at full rate, second with random gaps and back-pressure
        for (int pass = 0; pass < 2; pass++) begin
            random_mode = (pass == 1);
            for (int r = 0; r < rec_count; r++) begin
                run_record(r);
            end
        end

        if (errors == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

/* tb/eth_fcs_stim.txt */
# name path(0 tx,1 rx) payload_len base(hex) step(hex) mode exp_out_len exp_last_user
# payload byte i = base + i*step; tx mode 1 = user on input last
# rx mode 0 = raw bytes, 1 = correct fcs appended, 2 = fcs appended then one bit flipped
tx_pad20    0  20 01 01 0  64 0
tx_exact60  0  60 3c 05 0  64 0
tx_full100  0 100 a5 07 0 104 0
tx_abort    0  30 10 03 1  30 1
rx_good     1  60 01 01 1  60 0
rx_flip     1  60 01 01 2  60 1
rx_six      1   2 c3 11 1   2 0
rx_short    1   4 de 11 0   1 1
rx_five     1   5 20 02 0   1 1

/* files.f */
source/eth_pkg.sv
source/stream_pkg.sv
source/eth_crc_8.sv
source/stream_skid_reg.sv
source/eth_fcs_insert.sv
source/eth_fcs_check.sv
source/eth_fcs_top.sv
tb/eth_fcs_top_tb.sv
